/* flist.f */
verilog/cordic_pkg.sv
verilog/rotate_arbiter.sv
verilog/cordic_prep.sv
verilog/cordic_stage.sv
verilog/cordic_post.sv
verilog/cordic_rotator.sv
verilog/rotate_top.sv
tb/tb_clkgen.sv
tb/tb_rotate_top.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_rotate_top \
    -f flist.f \
    --Mdir obj_dir \
    -o sim_rotate

./obj_dir/sim_rotate

/* tb/tb_clkgen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
    parameter int RESET_CYCLES = 5
) (
    output logic o_clk,
    output logic o_rst_n
);

    // 8 ns period
    initial begin
        o_clk = 1'b0;
        forever #4 o_clk = ~o_clk;
    end

    // Release on a rising edge once the reset cycles are done
    initial begin
        o_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        o_rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

/* tb/tb_rotate_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rotate_top;

    localparam int ITERATIONS  = 16;
    localparam int VW          = cordic_pkg::VEC_W;
    localparam int AW          = cordic_pkg::ANG_W;
    localparam int NUM_ROWS    = 23;
    localparam int TOL         = 2;
    localparam int WAIT_LIMIT  = 50;
    localparam int DRAIN_LIMIT = 200;

    typedef struct packed {
        cordic_pkg::chan_e    chan;
        logic signed [VW-1:0] x;
        logic signed [VW-1:0] y;
        logic signed [AW-1:0] angle;
        logic signed [VW-1:0] exp_x;
        logic signed [VW-1:0] exp_y;
        logic                 pair;
    } row_t;

    typedef struct packed {
        logic signed [VW-1:0] x;
        logic signed [VW-1:0] y;
        int                   stamp;
    } exp_t;

    // Columns: channel, x, y, angle in degrees, expected x, expected y,
    // and a flag to start the row in the same cycle as the row before it
    localparam row_t ROWS [NUM_ROWS] = '{
        '{cordic_pkg::CH_A,  100,    0,   30,   87,   50, 1'b0},
        '{cordic_pkg::CH_B,    0,   80,  -60,   69,   40, 1'b0},
        '{cordic_pkg::CH_A,   50,  -50,   45,   71,    0, 1'b0},
        '{cordic_pkg::CH_B,  -40,   90,   10,  -55,   82, 1'b0},
        '{cordic_pkg::CH_A,  120,   30,  -90,   30, -120, 1'b0},
        '{cordic_pkg::CH_B,   64,   64,   90,  -64,   64, 1'b0},
        // Folded angles
        '{cordic_pkg::CH_A,  100,    0,  135,  -71,   71, 1'b0},
        '{cordic_pkg::CH_B,   60,  -30, -150,  -67,   -4, 1'b0},
        '{cordic_pkg::CH_A,   70,   20,  180,  -70,  -20, 1'b0},
        '{cordic_pkg::CH_B,  -90,   45, -180,   90,  -45, 1'b0},
        '{cordic_pkg::CH_A,   33,  -77,  120,   50,   67, 1'b0},
        // Saturation
        '{cordic_pkg::CH_A,  127,  127,   45,    0,  127, 1'b0},
        '{cordic_pkg::CH_B, -128, -128,   45,    0, -128, 1'b0},
        // Contention, pairs started together
        '{cordic_pkg::CH_A,   80,   10,   20,   72,   37, 1'b0},
        '{cordic_pkg::CH_B,  -50,   60,  -45,    7,   78, 1'b1},
        '{cordic_pkg::CH_A,   10,  100,   75,  -94,   36, 1'b0},
        '{cordic_pkg::CH_B,  100, -100,  170,  -81,  116, 1'b1},
        '{cordic_pkg::CH_A,  -60,  -60, -100,  -49,   70, 1'b0},
        '{cordic_pkg::CH_B,   25,    0,    0,   25,    0, 1'b1},
        // Back to back on one channel
        '{cordic_pkg::CH_B,  127,    0,   60,   64,  110, 1'b0},
        '{cordic_pkg::CH_B,    0, -127,   30,   64, -110, 1'b0},
        '{cordic_pkg::CH_B,   45,   45,  -30,   61,   16, 1'b0},
        '{cordic_pkg::CH_B, -100,   20,   90,  -20, -100, 1'b0}
    };

    logic                 clk;
    logic                 rst_n;
    logic                 start_a;
    logic                 start_b;
    cordic_pkg::rot_req_t req_a;
    cordic_pkg::rot_req_t req_b;
    logic                 busy_a;
    logic                 busy_b;
    cordic_pkg::rot_res_t res;
    logic                 res_valid;

    exp_t exp_a_q [$];
    exp_t exp_b_q [$];
    int   cycle_cnt = 0;
    int   idx;
    int   waited;
    logic paired;
    logic need_a;
    logic need_b;

    tb_clkgen #(
        .RESET_CYCLES (5)
    ) u_clkgen (
        .o_clk   (clk),
        .o_rst_n (rst_n)
    );

    rotate_top #(
        .ITERATIONS (ITERATIONS)
    ) i_dut (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_start_a   (start_a),
        .i_req_a     (req_a),
        .i_start_b   (start_b),
        .i_req_b     (req_b),
        .o_busy_a    (busy_a),
        .o_busy_b    (busy_b),
        .o_res       (res),
        .o_res_valid (res_valid)
    );

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic report_failure(input string line);
        $display("%s", line);
        $display("TEST FAILED");
    endtask

    function automatic bit within_tol(input logic signed [VW-1:0] got,
                                      input logic signed [VW-1:0] want);
        int diff;
        diff = int'(got) - int'(want);
        return (diff <= TOL) && (diff >= -TOL);
    endfunction

    task automatic check_reset_outputs();
        int cycles;
        cycles = 0;
        // Last pass is the first cycle out of reset
        do begin
            @(negedge clk);
            assert (!res_valid && !busy_a && !busy_b) else begin
                report_failure($sformatf("** Error at %0t: outputs not low around reset",
                                         $time));
                $fatal(1);
            end
            if (cycles >= WAIT_LIMIT) begin
                report_failure("Reset was never released");
                $fatal(1);
            end
            cycles++;
        end while (!rst_n);
    endtask

    task automatic wait_idle(input logic chk_a, input logic chk_b);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while ((chk_a && busy_a) || (chk_b && busy_b)) begin
            if (cycles >= WAIT_LIMIT) begin
                report_failure("Timed out waiting for a channel to leave busy");
                $fatal(1);
            end
            cycles++;
            @(negedge clk);
        end
    endtask

    // Called on a rising edge
    // Stamp is the count during the cycle the strobe is high
    task automatic apply_row(input row_t r);
        exp_t e;
        e.x     = r.exp_x;
        e.y     = r.exp_y;
        e.stamp = cycle_cnt + 1;
        if (r.chan == cordic_pkg::CH_A) begin
            start_a <= 1'b1;
            req_a   <= '{x: r.x, y: r.y, angle: r.angle, chan: cordic_pkg::CH_A};
            exp_a_q.push_back(e);
        end else begin
            start_b <= 1'b1;
            req_b   <= '{x: r.x, y: r.y, angle: r.angle, chan: cordic_pkg::CH_B};
            exp_b_q.push_back(e);
        end
    endtask

    task automatic check_result();
        exp_t e;
        logic empty;
        int   latency;
        e     = '0;
        empty = 1'b0;
        if (res.chan == cordic_pkg::CH_A) begin
            empty = (exp_a_q.size() == 0);
            if (!empty) begin
                e = exp_a_q.pop_front();
            end
        end else begin
            empty = (exp_b_q.size() == 0);
            if (!empty) begin
                e = exp_b_q.pop_front();
            end
        end
        assert (!empty) else begin
            report_failure("A result came back on a channel with no request outstanding");
            $fatal(1);
        end
        latency = cycle_cnt - e.stamp;
        assert (within_tol(res.x, e.x)) else begin
            report_failure($sformatf("** Error at %0t: channel %0d x is %0d, expected %0d",
                                     $time, res.chan, res.x, e.x));
            $fatal(1);
        end
        assert (within_tol(res.y, e.y)) else begin
            report_failure($sformatf("** Error at %0t: channel %0d y is %0d, expected %0d",
                                     $time, res.chan, res.y, e.y));
            $fatal(1);
        end
        assert (latency >= ITERATIONS + 1 && latency <= ITERATIONS + 2) else begin
            report_failure($sformatf("** Error at %0t: channel %0d latency is %0d cycles",
                                     $time, res.chan, latency));
            $fatal(1);
        end
    endtask

    // Results are sampled away from the driving edge
    always @(negedge clk) begin
        if (rst_n && res_valid) begin
            check_result();
        end
    end

    initial begin
        start_a = 1'b0;
        start_b = 1'b0;
        req_a   = '0;
        req_b   = '0;

        check_reset_outputs();

        idx = 0;
        while (idx < NUM_ROWS) begin
            paired = 1'b0;
            if (idx < NUM_ROWS - 1) begin
                paired = ROWS[idx + 1].pair;
            end
            need_a = (ROWS[idx].chan == cordic_pkg::CH_A);
            need_b = !need_a;
            if (paired) begin
                need_a = 1'b1;
                need_b = 1'b1;
            end
            wait_idle(need_a, need_b);
            @(posedge clk);
            apply_row(ROWS[idx]);
            if (paired) begin
                apply_row(ROWS[idx + 1]);
            end
            // One-cycle strobe
            @(posedge clk);
            start_a <= 1'b0;
            start_b <= 1'b0;
            idx = idx + (paired ? 2 : 1);
        end

        waited = 0;
        while (exp_a_q.size() != 0 || exp_b_q.size() != 0) begin
            if (waited >= DRAIN_LIMIT) begin
                report_failure("Timed out waiting for the remaining results");
                $fatal(1);
            end
            waited++;
            @(negedge clk);
        end

        // Quiet period to catch stray results
        repeat (ITERATIONS + 2) @(negedge clk);

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/cordic_pkg.sv */
`default_nettype none

package cordic_pkg;

    // External widths
    localparam int VEC_W = 8;
    localparam int ANG_W = 9;

    // Working widths inside the pipeline
    localparam int PROC_W  = 24;
    localparam int APROC_W = 20;

    localparam int MAX_ITER = 16;

    // atan(2^-i) in degrees, scaled by 2^(APROC_W-ANG_W)
    localparam logic [APROC_W-2:0] ATAN_TABLE [MAX_ITER] = '{
        19'd92160,
        19'd54405,
        19'd28746,
        19'd14592,
        19'd7324,
        19'd3666,
        19'd1833,
        19'd917,
        19'd458,
        19'd229,
        19'd115,
        19'd57,
        19'd29,
        19'd14,
        19'd7,
        19'd4
    };

    typedef enum logic {
        CH_A = 1'b0,
        CH_B = 1'b1
    } chan_e;

    typedef enum logic {
        PRIO_A = 1'b0,
        PRIO_B = 1'b1
    } arb_state_e;

    // Client request, angle in whole degrees
    typedef struct packed {
        logic signed [VEC_W-1:0] x;
        logic signed [VEC_W-1:0] y;
        logic signed [ANG_W-1:0] angle;
        chan_e                   chan;
    } rot_req_t;

    typedef struct packed {
        logic signed [VEC_W-1:0] x;
        logic signed [VEC_W-1:0] y;
        chan_e                   chan;
    } rot_res_t;

    // Carried from stage to stage
    typedef struct packed {
        logic signed [PROC_W-1:0]  x;
        logic signed [PROC_W-1:0]  y;
        logic signed [APROC_W-1:0] angle;
        logic                      valid;
        logic                      flip;
        chan_e                     chan;
    } stage_t;

endpackage

`default_nettype wire

/* verilog/cordic_post.sv */
`timescale 1ns/1ps
`default_nettype none

module cordic_post (
    input  cordic_pkg::stage_t   i_stage,
    output cordic_pkg::rot_res_t o_res,
    output logic                 o_res_valid
);

    localparam int VW   = cordic_pkg::VEC_W;
    localparam int PW   = cordic_pkg::PROC_W;
    localparam int DROP = PW - VW - 1;

    localparam logic signed [PW-1:0] HALF_LSB = PW'(1 << (DROP - 1));
    localparam logic signed [PW-1:0] SAT_HI   = PW'((1 << (VW - 1)) - 1);
    localparam logic signed [PW-1:0] SAT_LO   = PW'(-(1 << (VW - 1)));

    // Round, undo the fold, then clamp to 8 bits
    // Negation happens while still wide so -128 cannot wrap
    function automatic logic signed [VW-1:0] round_sat(
        input logic signed [PW-1:0] v,
        input logic                 neg
    );
        logic signed [PW-1:0] r;
        r = (v + HALF_LSB) >>> DROP;
        if (neg) begin
            r = -r;
        end
        if (r > SAT_HI) begin
            round_sat = SAT_HI[VW-1:0];
        end else if (r < SAT_LO) begin
            round_sat = SAT_LO[VW-1:0];
        end else begin
            round_sat = r[VW-1:0];
        end
    endfunction

    assign o_res = '{
        x:    round_sat(i_stage.x, i_stage.flip),
        y:    round_sat(i_stage.y, i_stage.flip),
        chan: i_stage.chan
    };

    assign o_res_valid = i_stage.valid;

endmodule

`default_nettype wire

/* verilog/cordic_prep.sv */
`timescale 1ns/1ps
`default_nettype none

module cordic_prep (
    input  logic                 i_valid,
    input  cordic_pkg::rot_req_t i_req,
    output cordic_pkg::stage_t   o_stage
);

    localparam int VW  = cordic_pkg::VEC_W;
    localparam int AW  = cordic_pkg::ANG_W;
    localparam int PW  = cordic_pkg::PROC_W;
    localparam int APW = cordic_pkg::APROC_W;
    // One bit of headroom kept above the scaled input
    localparam int UP  = PW - VW - 1;

    logic signed [AW-1:0] ang_in;
    logic signed [AW-1:0] ang_fold;
    logic                 flip;
    logic signed [PW-1:0] x_wide;
    logic signed [PW-1:0] y_wide;

    // Multiply by about 0.60725, the inverse CORDIC gain
    function automatic logic signed [PW-1:0] inv_gain(input logic signed [PW-1:0] v);
        inv_gain = (v >>> 1) + (v >>> 4) + (v >>> 5) + (v >>> 7)
                 + (v >>> 8) + (v >>> 10) + (v >>> 11) + (v >>> 12)
                 + (v >>> 14) + (v >>> 17) + (v >>> 18) + (v >>> 19)
                 + (v >>> 21) + (v >>> 22);
    endfunction

    // Fold into +-90 degrees, result gets negated at the end
    always_comb begin
        ang_in = i_req.angle;
        if (ang_in > 90) begin
            ang_fold = AW'(ang_in - 180);
            flip     = 1'b1;
        end else if (ang_in < -90) begin
            ang_fold = AW'(ang_in + 180);
            flip     = 1'b1;
        end else begin
            ang_fold = ang_in;
            flip     = 1'b0;
        end
    end

    // Sign extend then move up into the working range
    assign x_wide = {{(PW - VW){i_req.x[VW-1]}}, i_req.x} <<< UP;
    assign y_wide = {{(PW - VW){i_req.y[VW-1]}}, i_req.y} <<< UP;

    assign o_stage = '{
        x:     inv_gain(x_wide),
        y:     inv_gain(y_wide),
        angle: {ang_fold, {(APW - AW){1'b0}}},
        valid: i_valid,
        flip:  flip,
        chan:  i_req.chan
    };

endmodule

`default_nettype wire

/* verilog/cordic_rotator.sv */
`timescale 1ns/1ps
`default_nettype none

module cordic_rotator #(
    parameter int ITERATIONS = 16
) (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_issue,
    input  cordic_pkg::rot_req_t i_req,
    output cordic_pkg::rot_res_t o_res,
    output logic                 o_res_valid
);

    // Entry 0 is the prep output, entry ITERATIONS feeds post
    cordic_pkg::stage_t stage_chain [0:ITERATIONS];

    if (ITERATIONS < 8 || ITERATIONS > cordic_pkg::MAX_ITER) begin : g_bad_iter
        $error("ITERATIONS must be between 8 and MAX_ITER");
    end

    cordic_prep u_prep (
        .i_valid (i_issue),
        .i_req   (i_req),
        .o_stage (stage_chain[0])
    );

    for (genvar i = 0; i < ITERATIONS; i++) begin : g_stage
        cordic_stage #(
            .SHIFT (i)
        ) u_stage (
            .i_clk   (i_clk),
            .i_rst_n (i_rst_n),
            .i_stage (stage_chain[i]),
            .o_stage (stage_chain[i+1])
        );
    end

    cordic_post u_post (
        .i_stage     (stage_chain[ITERATIONS]),
        .o_res       (o_res),
        .o_res_valid (o_res_valid)
    );

endmodule

`default_nettype wire

/* verilog/cordic_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module cordic_stage #(
    parameter int SHIFT = 0
) (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  cordic_pkg::stage_t i_stage,
    output cordic_pkg::stage_t o_stage
);

    localparam int PW  = cordic_pkg::PROC_W;
    localparam int APW = cordic_pkg::APROC_W;
    // 100 degrees in working units
    localparam int RES_LIM = 100 << (APW - cordic_pkg::ANG_W);

    logic signed [APW-1:0] atan;
    logic signed [PW-1:0]  x_sh;
    logic signed [PW-1:0]  y_sh;
    logic signed [PW-1:0]  x_nxt;
    logic signed [PW-1:0]  y_nxt;
    logic signed [APW-1:0] ang_nxt;

    logic signed [PW-1:0]  x_q;
    logic signed [PW-1:0]  y_q;
    logic signed [APW-1:0] ang_q;
    logic                  flip_q;
    cordic_pkg::chan_e     chan_q;
    logic                  valid_q;

    assign atan = $signed({1'b0, cordic_pkg::ATAN_TABLE[SHIFT]});
    assign x_sh = i_stage.x >>> SHIFT;
    assign y_sh = i_stage.y >>> SHIFT;

    // Negative residual rotates clockwise
    always_comb begin
        if (i_stage.angle[APW-1]) begin
            x_nxt   = i_stage.x + y_sh;
            y_nxt   = i_stage.y - x_sh;
            ang_nxt = i_stage.angle + atan;
        end else begin
            x_nxt   = i_stage.x - y_sh;
            y_nxt   = i_stage.y + x_sh;
            ang_nxt = i_stage.angle - atan;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_stage.valid) begin
            x_q    <= x_nxt;
            y_q    <= y_nxt;
            ang_q  <= ang_nxt;
            flip_q <= i_stage.flip;
            chan_q <= i_stage.chan;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= i_stage.valid;
        end
    end

    assign o_stage = '{x: x_q, y: y_q, angle: ang_q, valid: valid_q, flip: flip_q, chan: chan_q};

    // Prep folding plus earlier stages keep the residual bounded
    a_residual_range: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        valid_q |-> (ang_q <= RES_LIM && ang_q >= -RES_LIM));

endmodule

`default_nettype wire

/* verilog/rotate_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module rotate_arbiter (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_start_a,
    input  cordic_pkg::rot_req_t i_req_a,
    input  logic                 i_start_b,
    input  cordic_pkg::rot_req_t i_req_b,
    output logic                 o_busy_a,
    output logic                 o_busy_b,
    output logic                 o_issue,
    output cordic_pkg::rot_req_t o_issue_req
);

    cordic_pkg::rot_req_t   req_a_q;
    cordic_pkg::rot_req_t   req_b_q;
    logic                   pend_a;
    logic                   pend_b;
    cordic_pkg::arb_state_e prio_q;
    logic                   pick_b;

    // B wins when alone or when it holds priority
    assign pick_b = pend_b && (!pend_a || prio_q == cordic_pkg::PRIO_B);

    assign o_issue     = pend_a || pend_b;
    assign o_issue_req = pick_b ? req_b_q : req_a_q;
    assign o_busy_a    = pend_a;
    assign o_busy_b    = pend_b;

    // Stored requests, tagged with their channel
    always_ff @(posedge i_clk) begin
        if (i_start_a) begin
            req_a_q      <= i_req_a;
            req_a_q.chan <= cordic_pkg::CH_A;
        end
        if (i_start_b) begin
            req_b_q      <= i_req_b;
            req_b_q.chan <= cordic_pkg::CH_B;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pend_a <= 1'b0;
            pend_b <= 1'b0;
            prio_q <= cordic_pkg::PRIO_A;
        end else begin
            if (i_start_a) begin
                pend_a <= 1'b1;
            end else if (pend_a && !pick_b) begin
                pend_a <= 1'b0;
            end
            if (i_start_b) begin
                pend_b <= 1'b1;
            end else if (pick_b) begin
                pend_b <= 1'b0;
            end
            // Priority only moves on contention
            if (pend_a && pend_b) begin
                prio_q <= pick_b ? cordic_pkg::PRIO_A : cordic_pkg::PRIO_B;
            end
        end
    end

    a_no_start_a_busy: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_start_a |-> !o_busy_a);
    a_no_start_b_busy: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_start_b |-> !o_busy_b);

    // An issue comes from a fresh strobe or from a request that lost the last round
    a_issue_had_req: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_issue |-> $past(i_start_a || i_start_b || (o_busy_a && o_busy_b)));

endmodule

`default_nettype wire

/* verilog/rotate_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rotate_top #(
    parameter int ITERATIONS = 16
) (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_start_a,
    input  cordic_pkg::rot_req_t i_req_a,
    input  logic                 i_start_b,
    input  cordic_pkg::rot_req_t i_req_b,
    output logic                 o_busy_a,
    output logic                 o_busy_b,
    output cordic_pkg::rot_res_t o_res,
    output logic                 o_res_valid
);

    logic                 issue;
    cordic_pkg::rot_req_t issue_req;

    rotate_arbiter u_arbiter (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_start_a   (i_start_a),
        .i_req_a     (i_req_a),
        .i_start_b   (i_start_b),
        .i_req_b     (i_req_b),
        .o_busy_a    (o_busy_a),
        .o_busy_b    (o_busy_b),
        .o_issue     (issue),
        .o_issue_req (issue_req)
    );

    cordic_rotator #(
        .ITERATIONS (ITERATIONS)
    ) u_rotator (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_issue     (issue),
        .i_req       (issue_req),
        .o_res       (o_res),
        .o_res_valid (o_res_valid)
    );

endmodule

`default_nettype wire
